/* source/tau_cfg_pkg.sv */
// ====================
// Size constants for one systolic array cell datapath
// Changing VSIZE or DATA_BW changes every link port width
// LINK_FIFO_DEPTH must be at least 1
// ====================

package tau_cfg_pkg;

	// ====================
	// Datapath shape
	// ====================

	// Number of data lanes carried by one vector
	localparam int VSIZE = 4;

	// Width of one lane in bits
	localparam int DATA_BW = 8;

	// ====================
	// Link buffering
	// ====================

	// Entries held by the shared bidirectional queue
	// One entry per vector in flight across both directions
	// Deeper queues only add latency tolerance
	// They do not change ordering
	localparam int LINK_FIFO_DEPTH = 4;

endpackage

/* source/tau_link_pkg.sv */
// ====================
// Types carried on the cell link
// Lane 0 is packed in the most significant position
// The direction tag sits above the lane vector in a FIFO entry
// ====================

package tau_link_pkg;

	import tau_cfg_pkg::*;

	// ====================
	// Direction tag
	// ====================

	// Selects the destination of a buffered vector
	// DIR_FWD goes to destination 0
	// DIR_REV goes to destination 1
	typedef enum logic {
		DIR_FWD = 1'b0,
		DIR_REV = 1'b1
	} dir_t;

	// ====================
	// Lane vector
	// ====================

	// VSIZE lanes of DATA_BW bits each
	// Ascending lane range puts lane 0 at the top bits
	// Same packing order as the older unpacked lane ports
	typedef logic [0:VSIZE-1][DATA_BW-1:0] lane_vec_t;

	// ====================
	// Queue entry
	// ====================

	// Word stored in the link FIFO
	// Tag first so it lands in the MSB of the entry
	typedef struct packed {
		dir_t      dir;
		lane_vec_t vec;
	} link_entry_t;

endpackage

/* source/sync_fifo.sv */
// ====================
// Register array FIFO with rdy/ack on both sides
// Input ack may depend combinationally on out_ack when full
// Head entry is always visible on out_data while out_rdy is high
// ====================

module sync_fifo
	import tau_cfg_pkg::*;
	import tau_link_pkg::*;
#(
	parameter int  DEPTH   = LINK_FIFO_DEPTH,
	parameter type entry_t = link_entry_t
) (
	input  logic   clk,
	input  logic   rst_n,

	// Write side
	input  logic   in_rdy,
	output logic   in_ack,
	input  entry_t in_data,

	// Read side
	output logic   out_rdy,
	input  logic   out_ack,
	output entry_t out_data
);

	// ====================
	// Local sizes
	// ====================

	// Pointer needs at least one bit even for a single entry
	localparam int PTR_BW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

	// Count must reach DEPTH itself
	localparam int CNT_BW = $clog2(DEPTH + 1);

	// ====================
	// Storage and state
	// ====================

	// Entry registers
	entry_t mem [DEPTH];

	// Next slot to write
	logic [PTR_BW-1:0] wr_ptr;

	// Current head slot
	logic [PTR_BW-1:0] rd_ptr;

	// Number of valid entries
	logic [CNT_BW-1:0] count;

	// Status flags
	logic full;
	logic empty;

	// Handshake strobes
	logic push;
	logic pop;

	// ====================
	// Pointer step
	// ====================

	// Advance with wrap at DEPTH
	// Works for depths that are not a power of two
	function automatic logic [PTR_BW-1:0] next_ptr(input logic [PTR_BW-1:0] ptr);
		logic [PTR_BW-1:0] nxt;
		if (ptr == PTR_BW'(DEPTH - 1)) begin
			nxt = '0;
		end else begin
			nxt = ptr + 1'b1;
		end
		return nxt;
	endfunction

	// ====================
	// Flags and handshake
	// ====================

	always_comb begin
		// Both flags straight from the count
		full  = (count == CNT_BW'(DEPTH));
		empty = (count == '0);

		// Head is offered whenever something is stored
		out_rdy = !empty;
		pop     = out_rdy && out_ack;

		// A pop in this cycle frees a slot for the writer
		// so a full queue still takes a new entry then
		in_ack = in_rdy && (!full || pop);
		push   = in_ack;
	end

	// Head goes out directly from the array
	// Value is meaningless while empty
	assign out_data = mem[rd_ptr];

	// ====================
	// Write pointer
	// ====================

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
		end else if (push) begin
			wr_ptr <= next_ptr(wr_ptr);
		end
	end

	// ====================
	// Read pointer
	// ====================

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rd_ptr <= '0;
		end else if (pop) begin
			rd_ptr <= next_ptr(rd_ptr);
		end
	end

	// ====================
	// Occupancy
	// ====================

	// Push plus pop in one cycle leaves the count as it is
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			count <= '0;
		end else begin
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// ====================
	// Entry registers
	// ====================

	// Payload only, no reset
	// Written slot becomes visible at the head one cycle later
	always_ff @(posedge clk) begin
		if (push) begin
			mem[wr_ptr] <= in_data;
		end
	end

endmodule

/* source/bidir_fifo.sv */
// ====================
// Bidirectional link FIFO for one systolic cell
// Forward source wins when both sources request together
// One shared queue keeps a global order, so the head blocks both directions
// ====================

module bidir_fifo
	import tau_cfg_pkg::*;
	import tau_link_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,

	// Forward source
	input  logic      src0_rdy,
	output logic      src0_ack,
	input  lane_vec_t src0_data,

	// Reverse source
	input  logic      src1_rdy,
	output logic      src1_ack,
	input  lane_vec_t src1_data,

	// Forward destination
	output logic      dst0_rdy,
	input  logic      dst0_ack,

	// Reverse destination
	output logic      dst1_rdy,
	input  logic      dst1_ack,

	// Data shared by both destinations
	output lane_vec_t dst_data
);

	// ====================
	// Internal handshakes
	// ====================

	// Merged write side of the queue
	logic        src_rdy;
	logic        src_ack;
	link_entry_t src_entry;

	// Read side of the queue
	logic        dst_rdy;
	logic        dst_ack;
	link_entry_t dst_entry;

	// ====================
	// Merge front
	// ====================

	// Request towards the queue from either source
	assign src_rdy = src0_rdy || src1_rdy;

	// Fixed priority select of the entry
	always_comb begin
		if (src0_rdy) begin
			// Forward source has priority
			src_entry.dir = DIR_FWD;
			src_entry.vec = src0_data;
		end else begin
			// Reverse source only when forward is idle
			// Contents are ignored when neither requests
			src_entry.dir = DIR_REV;
			src_entry.vec = src1_data;
		end
	end

	// Acks back to the sources
	always_comb begin
		// Forward takes every accept while it requests
		src0_ack = src0_rdy && src_ack;

		// Reverse waits out any forward request
		// Its data must stay stable until this goes high
		src1_ack = src1_rdy && !src0_rdy && src_ack;
	end

	// ====================
	// Shared queue
	// ====================

	// Tagged vectors wait here in acceptance order
	sync_fifo #(
		.DEPTH   (LINK_FIFO_DEPTH),
		.entry_t (link_entry_t)
	) u_fifo (
		.clk      (clk),
		.rst_n    (rst_n),
		.in_rdy   (src_rdy),
		.in_ack   (src_ack),
		.in_data  (src_entry),
		.out_rdy  (dst_rdy),
		.out_ack  (dst_ack),
		.out_data (dst_entry)
	);

	// ====================
	// Direction split
	// ====================

	// Head tag picks exactly one destination
	always_comb begin
		dst0_rdy = dst_rdy && (dst_entry.dir == DIR_FWD);
		dst1_rdy = dst_rdy && (dst_entry.dir == DIR_REV);
	end

	// Only the addressed destination can ack
	// since the other one never sees rdy
	assign dst_ack = dst0_ack || dst1_ack;

	// Lane vector of the head goes to both destinations
	// Valid only while one of the destination rdys is high
	assign dst_data = dst_entry.vec;

endmodule

/* tb/tb_bidir_fifo.sv */
// ====================
// Testbench for bidir_fifo with a queue model checked every cycle
// Destinations only ack while their own rdy is high
// ====================

module tb_bidir_fifo
	import tau_cfg_pkg::*;
	import tau_link_pkg::*;
;

	logic clk, rst_n;
	logic src0_rdy, src0_ack, src1_rdy, src1_ack;
	lane_vec_t src0_data, src1_data, dst_data;
	logic dst0_rdy, dst0_ack, dst1_rdy, dst1_ack;

	// Model queue and per-test counters
	link_entry_t model_q[$];
	int acc0, acc1, pops0, pops1;
	logic last_ack0, last_ack1;

	// Sends left on each source
	// Source rdy mode is 0 for always and 1 for random
	// Destination ack mode is 0 for off, 1 for on and 2 for random
	int rem0, rem1, rdy_mode, ack_mode;
	string test_name;
	logic [31:0] lfsr_state = 32'h534c;

	bidir_fifo DUT (.*);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// ====================
	// Random source
	// ====================

	// Taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic take_bits(input int n, output logic [31:0] val);
		val = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			val = {val[30:0], lfsr_state[31]};
		end
	endtask

	// ====================
	// Reference and checks
	// ====================

	// Entry the arbiter should write, forward first
	function automatic link_entry_t ref_arbitrate(input logic r0, input lane_vec_t d0,
			input lane_vec_t d1);
		link_entry_t e;
		e.dir = r0 ? DIR_FWD : DIR_REV;
		e.vec = r0 ? d0 : d1;
		return e;
	endfunction

	task automatic fail_now(input string msg);
		$display("%s", msg);
		$display("SIMULATION FAILED");
		$fatal(1);
	endtask

	task automatic check_vec(input string what, input lane_vec_t exp, input lane_vec_t act);
		if (exp !== act)
			fail_now($sformatf("error %s %s expected %h actual %h", test_name, what, exp, act));
	endtask

	task automatic check_dir(input string what, input dir_t exp, input dir_t act);
		if (exp !== act)
			fail_now($sformatf("error %s %s expected %s actual %s", test_name, what,
				exp.name(), act.name()));
	endtask

	task automatic check_flag(input string what, input logic exp, input logic act);
		if (exp !== act)
			fail_now($sformatf("error %s %s expected %b actual %b", test_name, what, exp, act));
	endtask

	task automatic check_count(input string what, input int exp, input int act);
		if (exp != act)
			fail_now($sformatf("error %s %s expected %0d actual %0d", test_name, what, exp, act));
	endtask

	// ====================
	// Monitor
	// ====================

	// Inputs settle well before the falling edge
	always @(negedge clk) begin
		if (rst_n) begin
			compare_cycle();
		end
	end

	task automatic compare_cycle();
		link_entry_t head;
		logic pop, accept;
		head = (model_q.size() > 0) ? model_q[0] : '0;
		// Exactly one destination sees the head
		check_flag("dst rdy", model_q.size() > 0, dst0_rdy || dst1_rdy);
		check_flag("both dst rdy", 1'b0, dst0_rdy && dst1_rdy);
		if (model_q.size() > 0) begin
			check_dir("head direction", head.dir, dst1_rdy ? DIR_REV : DIR_FWD);
			check_vec("dst_data", head.vec, dst_data);
		end
		pop = (dst0_rdy && dst0_ack) || (dst1_rdy && dst1_ack);
		// A pop frees a slot in the same cycle
		accept = (src0_rdy || src1_rdy) && (model_q.size() < LINK_FIFO_DEPTH || pop);
		check_flag("src0_ack", src0_rdy && accept, src0_ack);
		check_flag("src1_ack", src1_rdy && !src0_rdy && accept, src1_ack);
		if (pop) begin
			void'(model_q.pop_front());
			if (dst1_rdy) pops1++;
			else pops0++;
		end
		if (accept) begin
			model_q.push_back(ref_arbitrate(src0_rdy, src0_data, src1_data));
			if (src0_rdy) acc0++;
			else acc1++;
		end
		last_ack0 = src0_ack;
		last_ack1 = src1_ack;
	endtask

	// ====================
	// Stimulus
	// ====================

	task automatic pick(input int mode, output logic hit);
		logic [31:0] b;
		take_bits(2, b);
		hit = (mode == 0) || (b[1:0] != 2'b00);
	endtask

	// One clock of sources and destinations
	task automatic drive_cycle();
		logic [31:0] bits;
		logic hit;
		@(posedge clk);
		#10;
		// Sources hold rdy and data until their ack
		if (src0_rdy && last_ack0) begin
			src0_rdy = 1'b0;
			rem0--;
		end
		if (src1_rdy && last_ack1) begin
			src1_rdy = 1'b0;
			rem1--;
		end
		pick(rdy_mode, hit);
		if (!src0_rdy && rem0 > 0 && hit) begin
			take_bits(32, bits);
			src0_data = bits;
			src0_rdy = 1'b1;
		end
		pick(rdy_mode, hit);
		if (!src1_rdy && rem1 > 0 && hit) begin
			take_bits(32, bits);
			src1_data = bits;
			src1_rdy = 1'b1;
		end
		take_bits(1, bits);
		hit = (ack_mode == 1) || (ack_mode == 2 && bits[0]);
		dst0_ack = dst0_rdy && hit;
		dst1_ack = dst1_rdy && hit;
	endtask

	task automatic wait_drained(input int limit);
		int n;
		n = 0;
		while (rem0 > 0 || rem1 > 0 || src0_rdy || src1_rdy || model_q.size() > 0) begin
			if (n >= limit)
				fail_now($sformatf("test %s did not drain within %0d cycles", test_name, limit));
			drive_cycle();
			n++;
		end
	endtask

	task automatic wait_accepts(input int target, input int limit);
		int n;
		n = 0;
		while (acc0 + acc1 < target) begin
			if (n >= limit)
				fail_now($sformatf("no source ack within %0d cycles in %s", limit, test_name));
			drive_cycle();
			n++;
		end
	endtask

	task automatic start_test(input string name, input int n0, input int n1, input int rm,
			input int am);
		test_name = name;
		acc0 = 0;
		acc1 = 0;
		pops0 = 0;
		pops1 = 0;
		rem0 = n0;
		rem1 = n1;
		rdy_mode = rm;
		ack_mode = am;
	endtask

	// ====================
	// Test sequence
	// ====================

	initial begin
		{rst_n, src0_rdy, src1_rdy, dst0_ack, dst1_ack} = '0;
		src0_data = '0;
		src1_data = '0;
		{last_ack0, last_ack1} = '0;
		start_test("reset", 0, 0, 0, 0);
		repeat (4) @(posedge clk);
		#10 rst_n = 1'b1;
		@(negedge clk);
		#1;
		check_flag("dst0_rdy", 1'b0, dst0_rdy);
		check_flag("dst1_rdy", 1'b0, dst1_rdy);
		check_flag("src0_ack", 1'b0, src0_ack);
		check_flag("src1_ack", 1'b0, src1_ack);

		start_test("forward_only", 20, 0, 1, 2);
		wait_drained(500);
		check_count("dst0 outputs", 20, pops0);
		check_count("dst1 outputs", 0, pops1);

		start_test("mixed", 30, 30, 1, 2);
		wait_drained(2000);
		check_count("dst0 outputs", 30, pops0);
		check_count("dst1 outputs", 30, pops1);

		// Both sources request in the very first cycle
		start_test("simultaneous", 4, 4, 0, 1);
		wait_drained(200);
		check_count("dst0 outputs", 4, pops0);
		check_count("dst1 outputs", 4, pops1);

		// Fill with no destination ack, then release one slot
		start_test("backpressure", 6, 6, 0, 0);
		repeat (10) drive_cycle();
		check_count("accepts while full", LINK_FIFO_DEPTH, acc0 + acc1);
		ack_mode = 1;
		drive_cycle();
		ack_mode = 0;
		repeat (6) drive_cycle();
		check_count("accepts after one pop", LINK_FIFO_DEPTH + 1, acc0 + acc1);
		ack_mode = 2;
		wait_drained(500);

		// Reverse vector at the head, forward vectors behind it
		start_test("head_block", 0, 1, 0, 0);
		wait_accepts(1, 50);
		rem0 = 3;
		repeat (8) drive_cycle();
		check_flag("dst1_rdy at head", 1'b1, dst1_rdy);
		check_flag("dst0_rdy blocked", 1'b0, dst0_rdy);
		check_count("queued", 4, acc0 + acc1);
		ack_mode = 1;
		wait_drained(100);
		check_count("dst0 outputs", 3, pops0);

		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

/* flist.f */
source/tau_cfg_pkg.sv
source/tau_link_pkg.sv
source/sync_fifo.sv
source/bidir_fifo.sv
tb/tb_bidir_fifo.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the bidir_fifo testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module tb_bidir_fifo -f flist.f -o sim_bidir_fifo
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

./obj_dir/sim_bidir_fifo > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "SIMULATION FAILED" "$LOG"; then
	echo "Result: FAIL"
	exit 1
fi
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi
if ! grep -q "SIMULATION PASSED" "$LOG"; then
	echo "Simulation ended without a pass report"
	exit 1
fi

echo "Result: PASS"
exit 0
